/* Bender.yml */
package:
  name: rv_decoder

sources:
  - include_dirs:
      - design
    files:
      - design/rv_isa_pkg.sv
      - design/rv_ctrl_pkg.sv
      - design/rv_base_imm.sv
      - design/rv_base_ctrl.sv
      - design/rv_compressed_decode.sv
      - design/rv_decoder.sv
  - target: simulation
    include_dirs:
      - design
      - bench
    files:
      - bench/tb_rv_decoder.sv

/* bench/rv_decoder_ref.svh */
`ifndef RV_DECODER_REF_SVH
`define RV_DECODER_REF_SVH

// rv32i alu op from funct3, alt picks sub or sra
function automatic rv_ctrl_pkg::alu_op_e expected_alu_op(input logic [2:0] f3,
                                                         input logic alt);
   case (f3)
      3'd0:    return alt ? rv_ctrl_pkg::ALU_SUB : rv_ctrl_pkg::ALU_ADD;
      3'd1:    return rv_ctrl_pkg::ALU_SLL;
      3'd2:    return rv_ctrl_pkg::ALU_SLT;
      3'd3:    return rv_ctrl_pkg::ALU_SLTU;
      3'd4:    return rv_ctrl_pkg::ALU_XOR;
      3'd5:    return alt ? rv_ctrl_pkg::ALU_SRA : rv_ctrl_pkg::ALU_SRL;
      3'd6:    return rv_ctrl_pkg::ALU_OR;
      default: return rv_ctrl_pkg::ALU_AND;
   endcase
endfunction

// expected decoder output for one fetched word
function automatic rv_ctrl_pkg::decode_t decode_ref(input logic [31:0] w);
   rv_ctrl_pkg::decode_t d;
   logic [4:0]           op;
   logic [2:0]           f3;
   logic [4:0]           hi;
   logic [4:0]           lo;
   d  = '0; // zero also means add, fetch, regval selects
   op = w[6:2];
   hi = w[11:7];
   lo = w[6:2];
   if (w[1:0] == rv_isa_pkg::Q_BASE) begin
      f3       = w[14:12];
      d.rs1    = w[19:15];
      d.rs2    = w[24:20];
      d.rd     = hi;
      d.funct3 = f3;
      d.imm    = {{20{w[31]}}, w[31:20]}; // i format unless the opcode says otherwise
      case (op)
         rv_isa_pkg::OP_OP: begin
            d.alu_op      = (w[31:25] == rv_isa_pkg::F7_MULDIV) ?
                            rv_ctrl_pkg::alu_op_e'(int'(rv_ctrl_pkg::ALU_MUL) + f3) :
                            expected_alu_op(f3, w[31:25] == rv_isa_pkg::F7_ALT);
            d.wb_from_alu = 1'b1;
         end
         rv_isa_pkg::OP_OPIMM: begin
            d.alu_op      = expected_alu_op(f3, f3 == 3'd5 && w[30]); // no subi
            d.s2_sel      = rv_ctrl_pkg::S2_IMM;
            d.wb_from_alu = 1'b1;
         end
         rv_isa_pkg::OP_LOAD: begin
            d.s2_sel     = rv_ctrl_pkg::S2_IMM;
            d.next_stage = rv_ctrl_pkg::STAGE_LOAD;
         end
         rv_isa_pkg::OP_STORE: begin
            d.s2_sel     = rv_ctrl_pkg::S2_IMM;
            d.imm        = {{20{w[31]}}, w[31:25], w[11:7]};
            d.next_stage = rv_ctrl_pkg::STAGE_STORE;
         end
         rv_isa_pkg::OP_JAL, rv_isa_pkg::OP_JALR: begin
            d.write_reg        = 1'b1; // link, reg_in_sel stays alu
            d.s2_sel           = rv_ctrl_pkg::S2_IMM;
            d.next_pc_from_alu = 1'b1;
            if (op == rv_isa_pkg::OP_JAL) begin
               d.s1_sel = rv_ctrl_pkg::S1_PC;
               d.imm    = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
            end
         end
         rv_isa_pkg::OP_BRANCH: begin
            d.imm        = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
            d.next_stage = rv_ctrl_pkg::STAGE_BRANCH;
            if (f3[2:1] != 2'b01) // 010 and 011 are not branches
               d.branch_mask = 6'd1 << (f3[2] ? f3 - 3'd2 : f3);
         end
         rv_isa_pkg::OP_AUIPC: begin
            d.imm         = {w[31:12], 12'h000};
            d.s1_sel      = rv_ctrl_pkg::S1_PC;
            d.s2_sel      = rv_ctrl_pkg::S2_IMM;
            d.wb_from_alu = 1'b1;
         end
         rv_isa_pkg::OP_LUI: begin
            d.imm         = {w[31:12], 12'h000};
            d.wb_from_imm = 1'b1;
            d.reg_in_sel  = rv_ctrl_pkg::REGIN_IMM;
         end
         rv_isa_pkg::OP_MISCMEM: d.next_stage = rv_ctrl_pkg::STAGE_FETCH;
         rv_isa_pkg::OP_SYSTEM:  d.next_stage = rv_ctrl_pkg::STAGE_SYSTEM;
         default:                d.next_stage = rv_ctrl_pkg::STAGE_TRAP;
      endcase
   end else begin
      f3           = w[15:13];
      d.rs1        = hi;
      d.rd         = hi;
      d.rs2        = lo;
      d.funct3     = rv_isa_pkg::F3_LW;
      d.next_stage = rv_ctrl_pkg::STAGE_DEAD; // until a kept form matches
      if (w[1:0] == rv_isa_pkg::Q_C0) begin
         d.rs1    = 5'd8 + w[9:7]; // primed registers x8..x15
         d.rs2    = 5'd8 + w[4:2];
         d.rd     = d.rs2;
         d.s2_sel = rv_ctrl_pkg::S2_IMM;
         d.imm    = {w[5], w[12:10], w[6]} * 4;
         if (f3 == rv_isa_pkg::C0_LW)
            d.next_stage = rv_ctrl_pkg::STAGE_LOAD;
         else if (f3 == rv_isa_pkg::C0_SW)
            d.next_stage = rv_ctrl_pkg::STAGE_STORE;
      end else if (w[1:0] == rv_isa_pkg::Q_C1) begin
         if (f3 == rv_isa_pkg::C1_ADDI) begin
            d.s2_sel      = rv_ctrl_pkg::S2_IMM;
            d.imm         = 32'($signed({w[12], w[6:2]}));
            d.wb_from_alu = 1'b1;
            d.next_stage  = rv_ctrl_pkg::STAGE_FETCH;
         end
      end else begin
         case (f3)
            rv_isa_pkg::C2_SLLI: begin
               d.s2_sel      = rv_ctrl_pkg::S2_IMM;
               d.imm         = lo; // shamt, zero extended
               d.alu_op      = rv_ctrl_pkg::ALU_SLL;
               d.wb_from_alu = 1'b1; // flag stays even when dead
               if (!w[12])
                  d.next_stage = rv_ctrl_pkg::STAGE_FETCH;
            end
            rv_isa_pkg::C2_LWSP: begin
               d.rs1    = 5'd2;
               d.s2_sel = rv_ctrl_pkg::S2_IMM;
               d.imm    = {w[3:2], w[12], w[6:4]} * 4;
               if (hi != 5'd0)
                  d.next_stage = rv_ctrl_pkg::STAGE_LOAD;
            end
            rv_isa_pkg::C2_SWSP: begin
               d.rs1        = 5'd2;
               d.s2_sel     = rv_ctrl_pkg::S2_IMM;
               d.imm        = {w[8:7], w[12:9]} * 4;
               d.next_stage = rv_ctrl_pkg::STAGE_STORE;
            end
            rv_isa_pkg::C2_JR: begin
               if (!w[12] && lo == 5'd0 && hi != 5'd0) begin // c.jr
                  d.next_pc_from_alu = 1'b1;
                  d.next_stage       = rv_ctrl_pkg::STAGE_FETCH;
               end else if (!w[12] && lo != 5'd0) begin // c.mv
                  d.rs1         = 5'd0;
                  d.wb_from_alu = 1'b1;
                  d.next_stage  = rv_ctrl_pkg::STAGE_FETCH;
               end else if (w[12] && hi != 5'd0 && lo != 5'd0) begin // c.add
                  d.wb_from_alu = 1'b1;
                  d.next_stage  = rv_ctrl_pkg::STAGE_FETCH;
               end else if (w[12] && hi != 5'd0) begin // c.jalr links to ra
                  d.rd               = 5'd1;
                  d.write_reg        = 1'b1;
                  d.next_pc_from_alu = 1'b1;
                  d.next_stage       = rv_ctrl_pkg::STAGE_FETCH;
               end
            end
            default: d.next_stage = rv_ctrl_pkg::STAGE_DEAD;
         endcase
      end
   end
   return d;
endfunction

`endif

/* bench/tb_rv_decoder.sv */
`include "rv_decode_settings.svh"

module tb_rv_decoder;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int N_RANDOM = 1600;

   logic                 i_clk = 1'b0; // no edge at time zero
   logic                 i_rst_n;
   logic                 i_en;
   logic [`RV_ILEN-1:0]  i_instr;
   logic                 o_valid;
   rv_ctrl_pkg::decode_t o_dec;

   logic [31:0]          stim[$]; // words still to send
   rv_ctrl_pkg::decode_t expq[$]; // one entry per enabled cycle
   rv_ctrl_pkg::decode_t held;    // o_dec must show this while idle
   logic                 en_prev; // i_en as seen one cycle back
   int                   n_sent;
   int                   n_checked;
   int                   cycles;
   int                   max_cycles;

   `include "rv_decoder_ref.svh"

   rv_decoder rv_decoder_i (
      .i_clk   (i_clk),
      .i_rst_n (i_rst_n),
      .i_en    (i_en),
      .i_instr (i_instr),
      .o_valid (o_valid),
      .o_dec   (o_dec)
   );

   always #5 i_clk = ~i_clk;

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("Test FAILED");
      $fatal(1);
   endtask

   task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] want);
      if (got !== want)
         abort_run($sformatf("MISMATCH %s got 0x%0h expected 0x%0h", name, got, want));
   endtask

   task automatic compare_dec(input rv_ctrl_pkg::decode_t got, input rv_ctrl_pkg::decode_t want);
      check_val("o_dec.rs1", got.rs1, want.rs1);
      check_val("o_dec.rs2", got.rs2, want.rs2);
      check_val("o_dec.rd", got.rd, want.rd);
      check_val("o_dec.imm", got.imm, want.imm);
      check_val("o_dec.branch_mask", got.branch_mask, want.branch_mask);
      check_val("o_dec.alu_op", got.alu_op, want.alu_op);
      check_val("o_dec.s1_sel", got.s1_sel, want.s1_sel);
      check_val("o_dec.s2_sel", got.s2_sel, want.s2_sel);
      check_val("o_dec.next_stage", got.next_stage, want.next_stage);
      check_val("o_dec.wb_from_alu", got.wb_from_alu, want.wb_from_alu);
      check_val("o_dec.wb_from_imm", got.wb_from_imm, want.wb_from_imm);
      check_val("o_dec.next_pc_from_alu", got.next_pc_from_alu, want.next_pc_from_alu);
      check_val("o_dec.reg_in_sel", got.reg_in_sel, want.reg_in_sel);
      check_val("o_dec.funct3", got.funct3, want.funct3);
      check_val("o_dec.write_reg", got.write_reg, want.write_reg);
   endtask

   // directed sweeps first, then random words in every quadrant
   task automatic build_stimulus();
      logic [31:0] r;
      logic [6:0]  f7;
      logic [4:0]  hi;
      logic [4:0]  lo;
      for (int f3 = 0; f3 < 8; f3++) begin
         for (int k = 0; k < 4; k++) begin // plain, alt, muldiv, unused funct7
            r  = $urandom;
            f7 = (k == 0) ? 7'h00 : (k == 1) ? rv_isa_pkg::F7_ALT :
                 (k == 2) ? rv_isa_pkg::F7_MULDIV : 7'h11;
            stim.push_back({f7, r[24:15], f3[2:0], r[11:7], rv_isa_pkg::OP_OP, 2'b11});
         end
         for (int b30 = 0; b30 < 2; b30++) begin // srli vs srai
            r = $urandom;
            stim.push_back({r[31], b30[0], r[29:15], f3[2:0], r[11:7],
                            rv_isa_pkg::OP_OPIMM, 2'b11});
         end
         r = $urandom;
         stim.push_back({r[31:15], f3[2:0], r[11:7], rv_isa_pkg::OP_BRANCH, 2'b11});
      end
      for (int op = 0; op < 64; op++) begin // all 32 major opcodes, twice
         r = $urandom;
         stim.push_back({r[31:7], op[4:0], 2'b11});
      end
      // v = quadrant, funct3, then bit 12 / rd nonzero / rs2 nonzero
      for (int v = 0; v < 192; v++) begin
         r  = $urandom;
         hi = v[1] ? {r[11:8], 1'b1} : 5'd0;
         lo = v[2] ? {r[6:3], 1'b1} : 5'd0;
         stim.push_back({r[31:16], v[5:3], v[0], hi, lo, 2'(v / 64)});
      end
      for (int i = 0; i < N_RANDOM; i++) begin
         r = $urandom;
         if ($urandom_range(0, 1) == 0)
            r[1:0] = 2'b11;
         else
            r[1:0] = 2'($urandom_range(0, 2)); // upper half is noise
         stim.push_back(r);
      end
   endtask

   initial begin : stimulus
      logic [31:0] w;
      i_rst_n   = 1'b0;
      i_en      = 1'b0;
      i_instr   = '0;
      held      = '0; // reset value of o_dec
      en_prev   = 1'b0;
      n_sent    = 0;
      n_checked = 0;
      cycles    = 0;
      void'($urandom(32'hee88455b));
      build_stimulus();
      max_cycles = stim.size() * 3 / 2 + 200; // about one idle cycle in four
      repeat (3) @(posedge i_clk);
      i_rst_n <= 1'b1;
      while (stim.size() != 0) begin
         @(posedge i_clk);
         if ($urandom_range(0, 3) == 0) begin
            i_en    <= 1'b0;
            i_instr <= $urandom; // must not leak into o_dec
         end else begin
            w = stim.pop_front();
            i_en    <= 1'b1;
            i_instr <= w;
            expq.push_back(decode_ref(w));
            n_sent++;
         end
      end
      @(posedge i_clk);
      i_en <= 1'b0;
      while (expq.size() != 0) @(posedge i_clk);
      repeat (2) @(negedge i_clk); // valid drops, hold checked
      #1; // last negedge compare done
      if (n_checked != n_sent) begin
         abort_run("number of results differs from instructions sent");
      end else begin
         $display("Test OK");
         $finish;
      end
   end

   // outputs sampled mid cycle, away from the edge
   always @(negedge i_clk) begin
      if (o_valid !== en_prev)
         abort_run(en_prev ? "o_valid missing one cycle after i_en"
                           : "o_valid high without i_en in the cycle before");
      else if (o_valid && expq.size() == 0)
         abort_run("o_valid high with no instruction outstanding");
      else begin
         if (o_valid) begin
            held = expq.pop_front();
            n_checked++;
         end
         compare_dec(o_dec, held); // idle cycles hold the last result
         en_prev = i_en;
      end
   end

   always @(posedge i_clk) begin
      cycles <= cycles + 1;
      if (cycles >= max_cycles)
         abort_run("timeout, results did not finish within the cycle limit");
   end

endmodule

/* design/rv_base_ctrl.sv */
`include "rv_decode_settings.svh"

module rv_base_ctrl (
   input  logic [`RV_ILEN-1:0]     i_instr,
   output rv_ctrl_pkg::base_ctrl_t o_ctrl
);

   rv_isa_pkg::opcode_e opcode;
   logic [2:0]          funct3;
   logic [6:0]          funct7;

   assign opcode = rv_isa_pkg::opcode_e'(i_instr[6:2]);
   assign funct3 = i_instr[14:12];
   assign funct7 = i_instr[31:25];

   // integer ops, shared by op and op-imm
   function automatic rv_ctrl_pkg::alu_op_e alu_base(input logic [2:0] f3,
                                                      input logic sub,
                                                      input logic sra);
      case (f3)
         rv_isa_pkg::F3_ADD:  return sub ? rv_ctrl_pkg::ALU_SUB : rv_ctrl_pkg::ALU_ADD;
         rv_isa_pkg::F3_SLL:  return rv_ctrl_pkg::ALU_SLL;
         rv_isa_pkg::F3_SLT:  return rv_ctrl_pkg::ALU_SLT;
         rv_isa_pkg::F3_SLTU: return rv_ctrl_pkg::ALU_SLTU;
         rv_isa_pkg::F3_XOR:  return rv_ctrl_pkg::ALU_XOR;
         rv_isa_pkg::F3_SRL:  return sra ? rv_ctrl_pkg::ALU_SRA : rv_ctrl_pkg::ALU_SRL;
         rv_isa_pkg::F3_OR:   return rv_ctrl_pkg::ALU_OR;
         default:             return rv_ctrl_pkg::ALU_AND;
      endcase
   endfunction

   // m extension, funct3 picks mul/div/rem flavour
   function automatic rv_ctrl_pkg::alu_op_e alu_mext(input logic [2:0] f3);
      case (f3)
         3'd0:    return rv_ctrl_pkg::ALU_MUL;
         3'd1:    return rv_ctrl_pkg::ALU_MULH;
         3'd2:    return rv_ctrl_pkg::ALU_MULHSU;
         3'd3:    return rv_ctrl_pkg::ALU_MULHU;
         3'd4:    return rv_ctrl_pkg::ALU_DIV;
         3'd5:    return rv_ctrl_pkg::ALU_DIVU;
         3'd6:    return rv_ctrl_pkg::ALU_REM;
         default: return rv_ctrl_pkg::ALU_REMU;
      endcase
   endfunction

   always_comb begin
      o_ctrl        = '0;
      o_ctrl.alu_op = rv_ctrl_pkg::ALU_ADD;
      o_ctrl.rs1    = i_instr[19:15]; // regfile read starts during decode
      o_ctrl.rs2    = i_instr[24:20];
      o_ctrl.rd     = i_instr[11:7];
      o_ctrl.funct3 = funct3;

      case (opcode)
         rv_isa_pkg::OP_OP: begin
            o_ctrl.s2_sel = rv_ctrl_pkg::S2_REGVAL2;
            if (funct7 == rv_isa_pkg::F7_MULDIV)
               o_ctrl.alu_op = alu_mext(funct3);
            else
               o_ctrl.alu_op = alu_base(funct3, funct7 == rv_isa_pkg::F7_ALT,
                                        funct7 == rv_isa_pkg::F7_ALT);
            o_ctrl.wb_from_alu = 1'b1; // written back in fetch
            o_ctrl.next_stage  = rv_ctrl_pkg::STAGE_FETCH;
         end
         rv_isa_pkg::OP_OPIMM: begin
            o_ctrl.s2_sel      = rv_ctrl_pkg::S2_IMM;
            o_ctrl.alu_op      = alu_base(funct3, 1'b0, i_instr[30]); // no subi
            o_ctrl.wb_from_alu = 1'b1;
            o_ctrl.next_stage  = rv_ctrl_pkg::STAGE_FETCH;
         end
         rv_isa_pkg::OP_LOAD: begin // address on the alu
            o_ctrl.s2_sel     = rv_ctrl_pkg::S2_IMM;
            o_ctrl.next_stage = rv_ctrl_pkg::STAGE_LOAD;
         end
         rv_isa_pkg::OP_STORE: begin
            o_ctrl.s2_sel     = rv_ctrl_pkg::S2_IMM;
            o_ctrl.next_stage = rv_ctrl_pkg::STAGE_STORE;
         end
         rv_isa_pkg::OP_JAL, rv_isa_pkg::OP_JALR: begin
            o_ctrl.write_reg  = 1'b1; // link address
            o_ctrl.reg_in_sel = rv_ctrl_pkg::REGIN_ALU;
            o_ctrl.s1_sel     = (opcode == rv_isa_pkg::OP_JAL) ? rv_ctrl_pkg::S1_PC
                                                               : rv_ctrl_pkg::S1_REGVAL1;
            o_ctrl.s2_sel           = rv_ctrl_pkg::S2_IMM;
            o_ctrl.next_pc_from_alu = 1'b1; // target from alu
            o_ctrl.next_stage       = rv_ctrl_pkg::STAGE_FETCH;
         end
         rv_isa_pkg::OP_BRANCH: begin // compare rs1 with rs2
            o_ctrl.s2_sel     = rv_ctrl_pkg::S2_REGVAL2;
            o_ctrl.next_stage = rv_ctrl_pkg::STAGE_BRANCH;
         end
         rv_isa_pkg::OP_AUIPC: begin
            o_ctrl.s1_sel      = rv_ctrl_pkg::S1_PC; // pc + imm
            o_ctrl.s2_sel      = rv_ctrl_pkg::S2_IMM;
            o_ctrl.wb_from_alu = 1'b1;
            o_ctrl.next_stage  = rv_ctrl_pkg::STAGE_FETCH;
         end
         rv_isa_pkg::OP_LUI: begin
            o_ctrl.wb_from_imm = 1'b1; // imm straight to rd
            o_ctrl.reg_in_sel  = rv_ctrl_pkg::REGIN_IMM;
            o_ctrl.next_stage  = rv_ctrl_pkg::STAGE_FETCH;
         end
         rv_isa_pkg::OP_MISCMEM: o_ctrl.next_stage = rv_ctrl_pkg::STAGE_FETCH; // nop
         rv_isa_pkg::OP_SYSTEM:  o_ctrl.next_stage = rv_ctrl_pkg::STAGE_SYSTEM;
         default:                o_ctrl.next_stage = rv_ctrl_pkg::STAGE_TRAP;
      endcase
   end

endmodule

/* design/rv_base_imm.sv */
`include "rv_decode_settings.svh"

module rv_base_imm (
   input  logic [`RV_ILEN-1:0]    i_instr,
   output logic [`RV_XLEN-1:0]    o_imm,
   output logic [`RV_BMASK_W-1:0] o_branch_mask
);

   rv_isa_pkg::opcode_e opcode;
   logic [2:0]          funct3;
   logic                sgn;

   assign opcode = rv_isa_pkg::opcode_e'(i_instr[6:2]);
   assign funct3 = i_instr[14:12];
   assign sgn    = i_instr[31]; // every format signs from bit 31

   always_comb begin
      case (opcode)
         rv_isa_pkg::OP_STORE: // s format
            o_imm = {{(`RV_XLEN-12){sgn}}, i_instr[31:25], i_instr[11:7]};
         rv_isa_pkg::OP_BRANCH: // b format, halfword aligned
            o_imm = {{(`RV_XLEN-12){sgn}}, i_instr[7], i_instr[30:25],
                     i_instr[11:8], 1'b0};
         rv_isa_pkg::OP_LUI, rv_isa_pkg::OP_AUIPC:
            o_imm = {i_instr[31:12], 12'b0}; // upper 20 bits
         rv_isa_pkg::OP_JAL: // j format
            o_imm = {{(`RV_XLEN-20){sgn}}, i_instr[19:12], i_instr[20],
                     i_instr[30:21], 1'b0};
         default: // i format, meaningless for op but harmless
            o_imm = {{(`RV_XLEN-12){sgn}}, i_instr[31:20]};
      endcase
   end

   // one hot condition for the branch unit
   always_comb begin
      o_branch_mask = '0;
      if (opcode == rv_isa_pkg::OP_BRANCH) begin
         case (funct3)
            rv_isa_pkg::F3_BEQ:  o_branch_mask[0] = 1'b1;
            rv_isa_pkg::F3_BNE:  o_branch_mask[1] = 1'b1;
            rv_isa_pkg::F3_BLT:  o_branch_mask[2] = 1'b1;
            rv_isa_pkg::F3_BGE:  o_branch_mask[3] = 1'b1;
            rv_isa_pkg::F3_BLTU: o_branch_mask[4] = 1'b1;
            rv_isa_pkg::F3_BGEU: o_branch_mask[5] = 1'b1;
            default:             o_branch_mask    = '0; // 010/011 unused
         endcase
      end
   end

endmodule

/* design/rv_compressed_decode.sv */
`include "rv_decode_settings.svh"

module rv_compressed_decode (
   input  logic [15:0]          i_cinstr,
   output rv_ctrl_pkg::decode_t o_dec
);

   logic [2:0]               c_funct3;
   logic [`RV_REG_IDX_W-1:0] f_hi; // rd/rs1 field
   logic [`RV_REG_IDX_W-1:0] f_lo; // rs2 field

   assign c_funct3 = i_cinstr[15:13];
   assign f_hi     = i_cinstr[11:7];
   assign f_lo     = i_cinstr[6:2];

   always_comb begin
      o_dec            = '0;
      o_dec.alu_op     = rv_ctrl_pkg::ALU_ADD;
      o_dec.funct3     = rv_isa_pkg::F3_LW; // only word access in rvc subset
      o_dec.rs1        = f_hi;
      o_dec.rd         = f_hi;
      o_dec.rs2        = f_lo;
      o_dec.next_stage = rv_ctrl_pkg::STAGE_DEAD; // overridden by kept forms

      case (rv_isa_pkg::quadrant_e'(i_cinstr[1:0]))
         rv_isa_pkg::Q_C0: begin
            o_dec.rs1    = {2'b01, i_cinstr[9:7]}; // x8..x15
            o_dec.rs2    = {2'b01, i_cinstr[4:2]};
            o_dec.rd     = {2'b01, i_cinstr[4:2]};
            o_dec.s2_sel = rv_ctrl_pkg::S2_IMM;
            o_dec.imm    = {{(`RV_XLEN-7){1'b0}}, i_cinstr[5], i_cinstr[12:10],
                            i_cinstr[6], 2'b00};
            case (c_funct3)
               rv_isa_pkg::C0_LW:       o_dec.next_stage = rv_ctrl_pkg::STAGE_LOAD;
               rv_isa_pkg::C0_SW:       o_dec.next_stage = rv_ctrl_pkg::STAGE_STORE;
               rv_isa_pkg::C0_ADDI4SPN: o_dec.next_stage = rv_ctrl_pkg::STAGE_DEAD;
               default:                 o_dec.next_stage = rv_ctrl_pkg::STAGE_DEAD;
            endcase
         end
         rv_isa_pkg::Q_C1: begin
            if (c_funct3 == rv_isa_pkg::C1_ADDI) begin // c.nop when all zero
               o_dec.s2_sel      = rv_ctrl_pkg::S2_IMM;
               o_dec.imm         = {{(`RV_XLEN-5){i_cinstr[12]}}, i_cinstr[6:2]};
               o_dec.wb_from_alu = 1'b1;
               o_dec.next_stage  = rv_ctrl_pkg::STAGE_FETCH;
            end
         end
         rv_isa_pkg::Q_C2: begin
            case (c_funct3)
               rv_isa_pkg::C2_SLLI: begin
                  o_dec.s2_sel      = rv_ctrl_pkg::S2_IMM;
                  o_dec.imm         = {{(`RV_XLEN-5){1'b0}}, i_cinstr[6:2]}; // shamt
                  o_dec.alu_op      = rv_ctrl_pkg::ALU_SLL;
                  o_dec.wb_from_alu = 1'b1;
                  if (!i_cinstr[12]) // shamt[5] reserved on rv32
                     o_dec.next_stage = rv_ctrl_pkg::STAGE_FETCH;
               end
               rv_isa_pkg::C2_LWSP: begin
                  o_dec.rs1    = 5'd2; // sp relative
                  o_dec.s2_sel = rv_ctrl_pkg::S2_IMM;
                  o_dec.imm    = {{(`RV_XLEN-8){1'b0}}, i_cinstr[3:2], i_cinstr[12],
                                  i_cinstr[6:4], 2'b00};
                  if (f_hi != '0) o_dec.next_stage = rv_ctrl_pkg::STAGE_LOAD;
               end
               rv_isa_pkg::C2_SWSP: begin
                  o_dec.rs1        = 5'd2;
                  o_dec.s2_sel     = rv_ctrl_pkg::S2_IMM;
                  o_dec.imm        = {{(`RV_XLEN-8){1'b0}}, i_cinstr[8:7],
                                      i_cinstr[12:9], 2'b00};
                  o_dec.next_stage = rv_ctrl_pkg::STAGE_STORE;
               end
               rv_isa_pkg::C2_JR: begin
                  o_dec.s2_sel = rv_ctrl_pkg::S2_REGVAL2;
                  if (!i_cinstr[12]) begin
                     if (f_lo == '0 && f_hi != '0) begin // c.jr
                        o_dec.next_pc_from_alu = 1'b1;
                        o_dec.next_stage       = rv_ctrl_pkg::STAGE_FETCH;
                     end else if (f_lo != '0) begin // c.mv is x0 + rs2
                        o_dec.rs1         = '0;
                        o_dec.wb_from_alu = 1'b1;
                        o_dec.next_stage  = rv_ctrl_pkg::STAGE_FETCH;
                     end
                  end else if (f_hi != '0 && f_lo != '0) begin // c.add
                     o_dec.wb_from_alu = 1'b1;
                     o_dec.next_stage  = rv_ctrl_pkg::STAGE_FETCH;
                  end else if (f_hi != '0) begin // c.jalr, link into ra
                     o_dec.rd               = 5'd1;
                     o_dec.write_reg        = 1'b1;
                     o_dec.reg_in_sel       = rv_ctrl_pkg::REGIN_ALU;
                     o_dec.next_pc_from_alu = 1'b1;
                     o_dec.next_stage       = rv_ctrl_pkg::STAGE_FETCH;
                  end
                  // ebreak and rd=0 add stay dead
               end
               default: o_dec.next_stage = rv_ctrl_pkg::STAGE_DEAD;
            endcase
         end
         default: o_dec.next_stage = rv_ctrl_pkg::STAGE_DEAD; // 32 bit word, not used
      endcase
   end

endmodule

/* design/rv_ctrl_pkg.sv */
`include "rv_decode_settings.svh"

package rv_ctrl_pkg;

   typedef enum logic [4:0] {
      ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR, ALU_SRL, ALU_SRA,
      ALU_OR, ALU_AND,
      ALU_MUL, ALU_MULH, ALU_MULHSU, ALU_MULHU, // m extension from here
      ALU_DIV, ALU_DIVU, ALU_REM, ALU_REMU
   } alu_op_e;

   typedef enum logic {S1_REGVAL1, S1_PC} s1_sel_e;         // alu port 1
   typedef enum logic [1:0] {S2_REGVAL2, S2_IMM} s2_sel_e;  // alu port 2
   typedef enum logic [1:0] {REGIN_ALU, REGIN_IMM} reg_in_sel_e;

   // what the execute unit does after this cycle
   typedef enum logic [2:0] {
      STAGE_FETCH, STAGE_LOAD, STAGE_STORE, STAGE_BRANCH,
      STAGE_SYSTEM, STAGE_TRAP, STAGE_DEAD // dead = unsupported encoding
   } stage_e;

   typedef struct packed {
      logic [`RV_REG_IDX_W-1:0] rs1;
      logic [`RV_REG_IDX_W-1:0] rs2;
      logic [`RV_REG_IDX_W-1:0] rd;
      logic [`RV_XLEN-1:0]      imm;
      logic [`RV_BMASK_W-1:0]   branch_mask;
      alu_op_e                  alu_op;
      s1_sel_e                  s1_sel;
      s2_sel_e                  s2_sel;
      stage_e                   next_stage;
      logic                     wb_from_alu;      // rd written in fetch
      logic                     wb_from_imm;      // lui
      logic                     next_pc_from_alu; // jumps
      reg_in_sel_e              reg_in_sel;
      logic [2:0]               funct3;           // load/store size for the lsu
      logic                     write_reg;        // link write during decode
   } decode_t;

   // base path control, imm and mask come from their own block
   typedef struct packed {
      logic [`RV_REG_IDX_W-1:0] rs1;
      logic [`RV_REG_IDX_W-1:0] rs2;
      logic [`RV_REG_IDX_W-1:0] rd;
      alu_op_e                  alu_op;
      s1_sel_e                  s1_sel;
      s2_sel_e                  s2_sel;
      stage_e                   next_stage;
      logic                     wb_from_alu;
      logic                     wb_from_imm;
      logic                     next_pc_from_alu;
      reg_in_sel_e              reg_in_sel;
      logic [2:0]               funct3;
      logic                     write_reg;
   } base_ctrl_t;

endpackage

/* design/rv_decode_settings.svh */
`ifndef RV_DECODE_SETTINGS_SVH
`define RV_DECODE_SETTINGS_SVH

// datapath and immediate width
`define RV_XLEN 32

// fetched instruction word, compressed forms sit in the low half
`define RV_ILEN 32

// x0..x31
`define RV_REG_IDX_W 5

// one bit per branch condition: beq bne blt bge bltu bgeu
`define RV_BMASK_W 6

`endif

/* design/rv_decoder.sv */
`include "rv_decode_settings.svh"

module rv_decoder (
   input  logic                 i_clk,
   input  logic                 i_rst_n,
   input  logic                 i_en,      // one decode per strobe
   input  logic [`RV_ILEN-1:0]  i_instr,
   output logic                 o_valid,   // pulse, cycle after i_en
   output rv_ctrl_pkg::decode_t o_dec
);

   logic [`RV_XLEN-1:0]     base_imm;
   logic [`RV_BMASK_W-1:0]  base_bmask;
   rv_ctrl_pkg::base_ctrl_t base_ctrl;
   rv_ctrl_pkg::decode_t    c_dec;
   rv_ctrl_pkg::decode_t    dec_nxt;

   rv_base_imm rv_base_imm_i (
      .i_instr       (i_instr),
      .o_imm         (base_imm),
      .o_branch_mask (base_bmask)
   );

   rv_base_ctrl rv_base_ctrl_i (
      .i_instr (i_instr),
      .o_ctrl  (base_ctrl)
   );

   rv_compressed_decode rv_compressed_decode_i (
      .i_cinstr (i_instr[15:0]), // upper half ignored for rvc
      .o_dec    (c_dec)
   );

   // quadrant picks the path
   always_comb begin
      if (rv_isa_pkg::quadrant_e'(i_instr[1:0]) == rv_isa_pkg::Q_BASE) begin
         dec_nxt = '{rs1:              base_ctrl.rs1,
                     rs2:              base_ctrl.rs2,
                     rd:               base_ctrl.rd,
                     imm:              base_imm,
                     branch_mask:      base_bmask,
                     alu_op:           base_ctrl.alu_op,
                     s1_sel:           base_ctrl.s1_sel,
                     s2_sel:           base_ctrl.s2_sel,
                     next_stage:       base_ctrl.next_stage,
                     wb_from_alu:      base_ctrl.wb_from_alu,
                     wb_from_imm:      base_ctrl.wb_from_imm,
                     next_pc_from_alu: base_ctrl.next_pc_from_alu,
                     reg_in_sel:       base_ctrl.reg_in_sel,
                     funct3:           base_ctrl.funct3,
                     write_reg:        base_ctrl.write_reg};
      end else begin
         dec_nxt = c_dec;
      end
   end

   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         o_valid <= 1'b0;
         o_dec   <= '0;
      end else begin
         o_valid <= i_en;
         if (i_en) o_dec <= dec_nxt; // holds otherwise
      end
   end

endmodule

/* design/rv_isa_pkg.sv */
package rv_isa_pkg;

   // major opcode, instr[6:2]
   typedef enum logic [4:0] {
      OP_LOAD    = 5'b00000,
      OP_MISCMEM = 5'b00011, // fence, decoded as nop
      OP_OPIMM   = 5'b00100,
      OP_AUIPC   = 5'b00101,
      OP_STORE   = 5'b01000,
      OP_OP      = 5'b01100,
      OP_LUI     = 5'b01101,
      OP_BRANCH  = 5'b11000,
      OP_JALR    = 5'b11001,
      OP_JAL     = 5'b11011,
      OP_SYSTEM  = 5'b11100
   } opcode_e;

   // instr[1:0], anything but 11 is a 16 bit word
   typedef enum logic [1:0] {
      Q_C0   = 2'b00,
      Q_C1   = 2'b01,
      Q_C2   = 2'b10,
      Q_BASE = 2'b11
   } quadrant_e;

   // branch funct3
   localparam logic [2:0] F3_BEQ  = 3'b000;
   localparam logic [2:0] F3_BNE  = 3'b001;
   localparam logic [2:0] F3_BLT  = 3'b100;
   localparam logic [2:0] F3_BGE  = 3'b101;
   localparam logic [2:0] F3_BLTU = 3'b110;
   localparam logic [2:0] F3_BGEU = 3'b111;

   // op / op-imm funct3, same codes for register and immediate forms
   localparam logic [2:0] F3_ADD  = 3'b000; // also sub
   localparam logic [2:0] F3_SLL  = 3'b001;
   localparam logic [2:0] F3_SLT  = 3'b010;
   localparam logic [2:0] F3_SLTU = 3'b011;
   localparam logic [2:0] F3_XOR  = 3'b100;
   localparam logic [2:0] F3_SRL  = 3'b101; // also sra
   localparam logic [2:0] F3_OR   = 3'b110;
   localparam logic [2:0] F3_AND  = 3'b111;

   localparam logic [2:0] F3_LW   = 3'b010; // word access

   // compressed funct3, instr[15:13]
   localparam logic [2:0] C0_ADDI4SPN = 3'b000;
   localparam logic [2:0] C0_LW       = 3'b010;
   localparam logic [2:0] C0_SW       = 3'b110;
   localparam logic [2:0] C1_ADDI     = 3'b000; // c.nop too
   localparam logic [2:0] C2_SLLI     = 3'b000;
   localparam logic [2:0] C2_LWSP     = 3'b010;
   localparam logic [2:0] C2_JR       = 3'b100; // jr mv ebreak jalr add
   localparam logic [2:0] C2_SWSP     = 3'b110;

   localparam logic [6:0] F7_MULDIV = 7'b0000001; // m extension
   localparam logic [6:0] F7_ALT    = 7'b0100000; // sub / sra

endpackage

/* verilog.f */
+incdir+design
+incdir+bench
design/rv_isa_pkg.sv
design/rv_ctrl_pkg.sv
design/rv_base_imm.sv
design/rv_base_ctrl.sv
design/rv_compressed_decode.sv
design/rv_decoder.sv
bench/tb_rv_decoder.sv
